//--- build.f
src/stream_pkg.sv
src/axis_distrib.sv
src/diff_stage.sv
src/peak_stage.sv
src/axis_fifo.sv
src/axis_join.sv
src/stream_top.sv
testbench/tb_clock.sv
testbench/tb_stream_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_stream_top -f build.f

# the pass line decides the result, a failing run exits non-zero itself
sim_out=$(./obj_dir/Vtb_stream_top 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'Testbench passed'; then
  exit 0
fi
exit 1

//--- src/axis_distrib.sv
// stream copy to all branches

module axis_distrib #(
  parameter int  num_outputs = 2,
  parameter type data_t      = logic [15:0]
) (
  input  logic                   s_axis_clk,
  input  logic                   s_axis_rst,

  // upstream side
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  data_t                  s_axis_tdata,

  // branch side, one shared data word
  output logic [num_outputs-1:0] m_axis_tvalid,
  input  logic [num_outputs-1:0] m_axis_tready,
  output data_t                  m_axis_tdata
);

  //////////////////////////////////////////////////////////////////////
  // take-mask bookkeeping
  //////////////////////////////////////////////////////////////////////

  // branches that already took the current sample
  logic [num_outputs-1:0] ready_all;
  // mask including transfers of this cycle
  logic [num_outputs-1:0] ready_all_next;
  // per-branch transfer this cycle
  logic [num_outputs-1:0] distrib_frame;
  // upstream transfer this cycle
  logic                   s_axis_frame;

  assign distrib_frame  = m_axis_tvalid & m_axis_tready;
  assign ready_all_next = ready_all | distrib_frame;

  // input completes only when the last branch takes its copy
  assign s_axis_tready = &ready_all_next;
  assign s_axis_frame  = s_axis_tvalid & s_axis_tready;

  // mask restarts with every new sample
  always_ff @(posedge s_axis_clk) begin
    if (s_axis_rst || s_axis_frame) begin
      ready_all <= '0;
    end else begin
      ready_all <= ready_all_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // branch output registers
  //////////////////////////////////////////////////////////////////////

  // reload valid only for branches still owing a transfer
  // served branches drop to low until the next sample
  always_ff @(posedge s_axis_clk) begin
    if (s_axis_rst) begin
      m_axis_tvalid <= '0;
    end else begin
      m_axis_tvalid <= ~ready_all_next & {num_outputs{s_axis_tvalid}};
    end
  end

  // shared word follows the input until the sample is done
  always_ff @(posedge s_axis_clk) begin
    if (!s_axis_tready) begin
      m_axis_tdata <= s_axis_tdata;
    end
  end

  // a set mask bit always comes from a real transfer on that branch
  // and the branch then sees valid low
  for (genvar n = 0; n < num_outputs; n++) begin : g_mask_chk
    a_mask_from_frame: assert property (
      @(posedge s_axis_clk) disable iff (s_axis_rst)
      ready_all[n] |-> !m_axis_tvalid[n] &&
                       ($past(ready_all[n]) || $past(distrib_frame[n]))
    );
  end

endmodule

//--- src/axis_fifo.sv
// small synchronous stream FIFO

module axis_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     s_axis_clk,
  input  logic     s_axis_rst,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // storage, no reset
  payload_t mem [depth];

  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  // occupancy, 0 to depth
  logic [$clog2(depth+1)-1:0] count;

  logic push;
  logic pop;

  assign in_ready  = count != $bits(count)'(depth);
  assign out_valid = count != '0;
  // head entry, visible the cycle after its push
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge s_axis_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers wrap at depth, any depth works
  always_ff @(posedge s_axis_clk) begin
    if (s_axis_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == $bits(wr_ptr)'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == $bits(rd_ptr)'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // full and not drained, nothing gets written
  a_no_push_full: assert property (
    @(posedge s_axis_clk) disable iff (s_axis_rst)
    (count == $bits(count)'(depth)) && !out_ready |=>
      (count == $bits(count)'(depth)) && $stable(wr_ptr)
  );

  // empty and nothing arriving, nothing gets read
  a_no_pop_empty: assert property (
    @(posedge s_axis_clk) disable iff (s_axis_rst)
    (count == '0) && !in_valid |=> (count == '0) && $stable(rd_ptr)
  );

endmodule

//--- src/axis_join.sv
// paired branch result join

module axis_join (
  input  logic                s_axis_clk,
  input  logic                s_axis_rst,

  // difference FIFO side
  input  logic                diff_valid,
  output logic                diff_ready,
  input  stream_pkg::diff_t   diff_data,

  // peak FIFO side
  input  logic                peak_valid,
  output logic                peak_ready,
  input  stream_pkg::peak_t   peak_data,

  // record output
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output stream_pkg::record_t m_axis_tdata
);

  // output register free or being taken
  logic out_free;
  // pop both sides this cycle
  logic load;

  assign out_free = !m_axis_tvalid || m_axis_tready;
  assign load     = diff_valid && peak_valid && out_free;

  // common ready keeps the branches in step
  assign diff_ready = load;
  assign peak_ready = load;

  always_ff @(posedge s_axis_clk) begin
    if (s_axis_rst) begin
      m_axis_tvalid <= 1'b0;
    end else if (out_free) begin
      m_axis_tvalid <= diff_valid && peak_valid;
    end
  end

  always_ff @(posedge s_axis_clk) begin
    if (load) begin
      m_axis_tdata <= '{diff: diff_data, peak: peak_data};
    end
  end

  // both sides pop together and land in the next record
  a_paired_pop: assert property (
    @(posedge s_axis_clk) disable iff (s_axis_rst)
    (diff_ready || peak_ready) |-> (diff_ready && peak_ready) ##1
      (m_axis_tvalid && m_axis_tdata.diff == $past(diff_data) &&
       m_axis_tdata.peak == $past(peak_data))
  );

endmodule

//--- src/diff_stage.sv
// first difference branch

module diff_stage (
  input  logic              s_axis_clk,
  input  logic              s_axis_rst,

  input  logic              in_valid,
  output logic              in_ready,
  input  stream_pkg::sample_t in_sample,

  output logic              out_valid,
  input  logic              out_ready,
  output stream_pkg::diff_t out_diff
);

  import stream_pkg::*;

  // last accepted sample, zero after reset
  sample_t prev_sample;
  logic    in_fire;

  // room when empty or being drained this cycle
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge s_axis_clk) begin
    if (s_axis_rst) begin
      out_valid   <= 1'b0;
      prev_sample <= '0;
    end else begin
      if (in_ready) begin
        out_valid <= in_valid;
      end
      if (in_fire) begin
        prev_sample <= in_sample;
      end
    end
  end

  // sign-extend both operands, 17-bit result never wraps
  always_ff @(posedge s_axis_clk) begin
    if (in_fire) begin
      out_diff <= {in_sample[sample_width-1], in_sample} -
                  {prev_sample[sample_width-1], prev_sample};
    end
  end

  // stalled result keeps both valid and value
  a_diff_hold: assert property (
    @(posedge s_axis_clk) disable iff (s_axis_rst)
    out_valid && !out_ready |=> out_valid && $stable(out_diff)
  );

endmodule

//--- src/peak_stage.sv
// running peak magnitude branch

module peak_stage (
  input  logic                s_axis_clk,
  input  logic                s_axis_rst,

  input  logic                in_valid,
  output logic                in_ready,
  input  stream_pkg::sample_t in_sample,

  output logic                out_valid,
  input  logic                out_ready,
  output stream_pkg::peak_t   out_peak
);

  import stream_pkg::*;

  // whole pipe moves together
  logic  advance;
  // stage one
  logic  s1_valid;
  peak_t s1_mag;
  // magnitude of the incoming sample
  peak_t mag;
  // running peak, also the output register
  peak_t peak_q;

  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  // two's complement negate
  // -32768 maps to 16'h8000 which reads as 32768 unsigned
  assign mag = in_sample[sample_width-1] ? peak_t'(~in_sample) + peak_t'(1) :
                                           peak_t'(in_sample);

  //////////////////////////////////////////////////////////////////////
  // stage one, magnitude
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    if (advance) begin
      s1_mag <= mag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage two, compare and update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    if (s_axis_rst) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
      peak_q    <= '0;
    end else if (advance) begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
      // bubbles leave the peak alone
      if (s1_valid && (s1_mag > peak_q)) begin
        peak_q <= s1_mag;
      end
    end
  end

  assign out_peak = peak_q;

  // peak is monotonic until the next reset
  a_peak_mono: assert property (
    @(posedge s_axis_clk) disable iff (s_axis_rst)
    !s_axis_rst |=> peak_q >= $past(peak_q)
  );

endmodule

//--- src/stream_pkg.sv
// sample analyzer shared types

//////////////////////////////////////////////////////////////////////
// sizing and payload definitions
//////////////////////////////////////////////////////////////////////

package stream_pkg;

  // input sample width
  localparam int sample_width = 16;

  // distributor fan-out used at the top level
  localparam int num_branches = 2;

  // entries per branch FIFO
  localparam int fifo_depth = 4;

  // raw signed input sample
  typedef logic signed [sample_width-1:0] sample_t;

  // one extra bit so sample minus sample cannot overflow
  typedef logic signed [sample_width:0] diff_t;

  // unsigned magnitude
  // 32768 from the most negative sample still fits
  typedef logic [sample_width-1:0] peak_t;

  // output record, diff in the upper bits and peak in the lower bits
  typedef struct packed {
    diff_t diff;
    peak_t peak;
  } record_t;

endpackage

//--- src/stream_top.sv
// sample analyzer top level

module stream_top (
  input  logic                s_axis_clk,
  input  logic                s_axis_rst,

  // sample input
  input  logic                s_axis_tvalid,
  output logic                s_axis_tready,
  input  stream_pkg::sample_t s_axis_tdata,

  // record output
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output stream_pkg::record_t m_axis_tdata
);

  import stream_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////////////////////////

  // distributor outputs, branch 0 diff, branch 1 peak
  logic [num_branches-1:0] dist_valid;
  logic [num_branches-1:0] dist_ready;
  sample_t                 dist_data;

  // stage to FIFO
  logic    diff_valid;
  logic    diff_ready;
  diff_t   diff_value;
  logic    peak_valid;
  logic    peak_ready;
  peak_t   peak_value;

  // FIFO to join
  logic    diff_fifo_valid;
  logic    diff_fifo_ready;
  diff_t   diff_fifo_data;
  logic    peak_fifo_valid;
  logic    peak_fifo_ready;
  peak_t   peak_fifo_data;

  //////////////////////////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////////////////////////

  axis_distrib #(
    .num_outputs (num_branches),
    .data_t      (sample_t)
  ) i_distrib (
    .s_axis_clk    (s_axis_clk),
    .s_axis_rst    (s_axis_rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axis_tvalid (dist_valid),
    .m_axis_tready (dist_ready),
    .m_axis_tdata  (dist_data)
  );

  diff_stage i_diff (
    .s_axis_clk (s_axis_clk),
    .s_axis_rst (s_axis_rst),
    .in_valid   (dist_valid[0]),
    .in_ready   (dist_ready[0]),
    .in_sample  (dist_data),
    .out_valid  (diff_valid),
    .out_ready  (diff_ready),
    .out_diff   (diff_value)
  );

  peak_stage i_peak (
    .s_axis_clk (s_axis_clk),
    .s_axis_rst (s_axis_rst),
    .in_valid   (dist_valid[1]),
    .in_ready   (dist_ready[1]),
    .in_sample  (dist_data),
    .out_valid  (peak_valid),
    .out_ready  (peak_ready),
    .out_peak   (peak_value)
  );

  // same FIFO, different payloads
  axis_fifo #(
    .payload_t (diff_t),
    .depth     (fifo_depth)
  ) diff_fifo (
    .s_axis_clk (s_axis_clk),
    .s_axis_rst (s_axis_rst),
    .in_valid   (diff_valid),
    .in_ready   (diff_ready),
    .in_data    (diff_value),
    .out_valid  (diff_fifo_valid),
    .out_ready  (diff_fifo_ready),
    .out_data   (diff_fifo_data)
  );

  axis_fifo #(
    .payload_t (peak_t),
    .depth     (fifo_depth)
  ) peak_fifo (
    .s_axis_clk (s_axis_clk),
    .s_axis_rst (s_axis_rst),
    .in_valid   (peak_valid),
    .in_ready   (peak_ready),
    .in_data    (peak_value),
    .out_valid  (peak_fifo_valid),
    .out_ready  (peak_fifo_ready),
    .out_data   (peak_fifo_data)
  );

  axis_join i_join (
    .s_axis_clk    (s_axis_clk),
    .s_axis_rst    (s_axis_rst),
    .diff_valid    (diff_fifo_valid),
    .diff_ready    (diff_fifo_ready),
    .diff_data     (diff_fifo_data),
    .peak_valid    (peak_fifo_valid),
    .peak_ready    (peak_fifo_ready),
    .peak_data     (peak_fifo_data),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata)
  );

endmodule

//--- testbench/tb_clock.sv
// clock and reset source

module tb_clock #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 5
) (
  output logic s_axis_clk,
  output logic s_axis_rst
);

  timeunit 1ns;
  timeprecision 1ps;

  // free running, low at time zero
  initial begin
    s_axis_clk = 1'b0;
    forever begin
      #(period_ns / 2);
      s_axis_clk = ~s_axis_clk;
    end
  end

  // sync reset, dropped just after an edge like the other inputs
  initial begin
    s_axis_rst = 1'b1;
    repeat (reset_cycles) @(posedge s_axis_clk);
    #1;
    s_axis_rst = 1'b0;
  end

endmodule

//--- testbench/tb_stream_top.sv
// sample analyzer testbench

module tb_stream_top;

  timeunit 1ns;
  timeprecision 1ps;

  import stream_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // run setup
  //////////////////////////////////////////////////////////////////////

  localparam int          num_samples       = 2000;
  localparam int          phase_len         = 500;
  localparam int          cycles_per_sample = 10;
  localparam int          timeout_cycles    = num_samples * cycles_per_sample;
  localparam int          idle_cycles       = 4;
  localparam int          drain_cycles      = 20;
  localparam int          drive_delay       = 1;
  localparam logic [31:0] lfsr_seed         = 32'h7f50_d074;
  // amplitude grows one bit every ramp_step samples
  localparam int          ramp_step         = 32;
  // 32767, -32768, 32767 starting here
  localparam int          extreme_idx       = 1700;
  localparam sample_t     sample_max        = {1'b0, {(sample_width-1){1'b1}}};
  localparam sample_t     sample_min        = {1'b1, {(sample_width-1){1'b0}}};
  // distributor, diff stage, two peak stages, both FIFOs, join register
  localparam int          inflight_limit    = 1 + 1 + 2 + 2 * fifo_depth + 1;

  logic    s_axis_clk;
  logic    s_axis_rst;
  logic    s_axis_tvalid;
  logic    s_axis_tready;
  sample_t s_axis_tdata;
  logic    m_axis_tvalid;
  logic    m_axis_tready;
  record_t m_axis_tdata;

  logic [31:0] lfsr_state;
  // expected fields in arrival order
  int          exp_diff_q[$];
  int          exp_peak_q[$];
  int          model_prev;
  int          model_peak;
  int          sent_count;
  int          in_count;
  int          out_count;
  int          cycle_count;
  int          step;
  logic        last_in_fire;
  // output stalled at the previous sample point
  logic        stall_seen;
  diff_t       held_diff;
  peak_t       held_peak;

  tb_clock #(
    .period_ns    (40),
    .reset_cycles (5)
  ) i_clock (
    .s_axis_clk (s_axis_clk),
    .s_axis_rst (s_axis_rst)
  );

  stream_top i_dut (
    .s_axis_clk    (s_axis_clk),
    .s_axis_rst    (s_axis_rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata)
  );

  //////////////////////////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, int expected, int actual);
    $display("Error at time %0d ns: %s expected %0d, actual %0d",
             $time, name, expected, actual);
    fail_run();
  endtask

  task automatic report_failure(string what);
    $display("Error at time %0d ns: %s", $time, what);
    fail_run();
  endtask

  //////////////////////////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // one step per bit taken
  // newest bit lands in bit 0
  function automatic logic [31:0] random_bits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // small samples first so the peak climbs slowly
  function automatic sample_t make_sample(int idx);
    logic [31:0] bits;
    sample_t     raw;
    int          shift;
    bits  = random_bits(sample_width);
    raw   = sample_t'(bits[sample_width-1:0]);
    shift = (idx < sample_width * ramp_step) ? (sample_width - 1 - idx / ramp_step) : 0;
    if (idx == extreme_idx || idx == extreme_idx + 2) begin
      return sample_max;
    end else if (idx == extreme_idx + 1) begin
      return sample_min;
    end
    return raw >>> shift;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // diff against the last accepted sample and peak over all magnitudes
  task automatic push_model(sample_t sample);
    int value;
    int mag;
    value = int'(sample);
    mag   = (value < 0) ? -value : value;
    if (mag > model_peak) begin
      model_peak = mag;
    end
    exp_diff_q.push_back(value - model_prev);
    exp_peak_q.push_back(model_peak);
    model_prev = value;
    in_count++;
    assert (exp_diff_q.size() <= inflight_limit)
      else report_failure("more samples accepted than the pipeline can hold in flight");
  endtask

  task automatic check_record(record_t rec);
    diff_t got_diff;
    peak_t got_peak;
    int    want_diff;
    int    want_peak;
    assert (exp_diff_q.size() > 0)
      else report_failure("output record with no accepted sample left to match it");
    got_diff  = rec.diff;
    got_peak  = rec.peak;
    want_diff = exp_diff_q.pop_front();
    want_peak = exp_peak_q.pop_front();
    assert (int'(got_diff) == want_diff)
      else report_mismatch("m_axis_tdata.diff", want_diff, int'(got_diff));
    assert (int'(got_peak) == want_peak)
      else report_mismatch("m_axis_tdata.peak", want_peak, int'(got_peak));
    out_count++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // per-cycle sampling and driving
  //////////////////////////////////////////////////////////////////////

  // handshakes seen mid-cycle complete at the next edge
  task automatic check_transfers();
    logic in_fire;
    logic out_fire;
    in_fire  = s_axis_tvalid && s_axis_tready;
    out_fire = m_axis_tvalid && m_axis_tready;
    // nothing comes out before the first sample goes in
    if (in_count == 0) begin
      assert (!m_axis_tvalid)
        else report_mismatch("m_axis_tvalid", 0, int'(m_axis_tvalid));
    end
    // stalled record must stay put
    if (stall_seen) begin
      assert (m_axis_tvalid)
        else report_mismatch("m_axis_tvalid", 1, int'(m_axis_tvalid));
      assert (m_axis_tdata.diff == held_diff)
        else report_mismatch("m_axis_tdata.diff", int'(held_diff), int'(m_axis_tdata.diff));
      assert (m_axis_tdata.peak == held_peak)
        else report_mismatch("m_axis_tdata.peak", int'(held_peak), int'(m_axis_tdata.peak));
    end
    stall_seen = m_axis_tvalid && !m_axis_tready;
    held_diff  = m_axis_tdata.diff;
    held_peak  = m_axis_tdata.peak;
    if (in_fire) begin
      push_model(s_axis_tdata);
    end
    if (out_fire) begin
      check_record(m_axis_tdata);
    end
    last_in_fire = in_fire;
  endtask

  // phase 0 steady, 1 output stalls, 2 input gaps, 3 both
  task automatic drive_inputs();
    int          phase;
    logic [31:0] pick;
    phase = (sent_count / phase_len > 3) ? 3 : sent_count / phase_len;
    // a raised valid holds its sample until the transfer
    if (last_in_fire || !s_axis_tvalid) begin
      pick = (phase >= 2) ? random_bits(1) : 32'd1;
      if (sent_count < num_samples && pick[0]) begin
        s_axis_tdata  = make_sample(sent_count);
        s_axis_tvalid = 1'b1;
        sent_count++;
      end else begin
        s_axis_tvalid = 1'b0;
      end
    end
    case (phase)
      1: begin
        pick = random_bits(1);
        m_axis_tready = pick[0];
      end
      3: begin
        pick = random_bits(2);
        m_axis_tready = pick[1:0] != 2'b00;
      end
      default: begin
        m_axis_tready = 1'b1;
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    m_axis_tready = 1'b0;
    lfsr_state    = lfsr_seed;
    model_prev    = 0;
    model_peak    = 0;
    sent_count    = 0;
    in_count      = 0;
    out_count     = 0;
    cycle_count   = 0;
    step          = 0;
    last_in_fire  = 1'b0;
    stall_seen    = 1'b0;
    held_diff     = '0;
    held_peak     = '0;
    wait (s_axis_rst === 1'b0);
    while (out_count < num_samples) begin
      @(negedge s_axis_clk);
      check_transfers();
      @(posedge s_axis_clk);
      #drive_delay;
      // a few quiet cycles to watch the output after reset
      if (step < idle_cycles) begin
        m_axis_tready = 1'b1;
      end else begin
        drive_inputs();
      end
      step++;
    end
    // ready stays high so any stray record transfers and gets matched
    m_axis_tready = 1'b1;
    // watch for stray records once everything is out
    repeat (drain_cycles) begin
      @(negedge s_axis_clk);
      check_transfers();
    end
    assert (in_count == num_samples)
      else report_mismatch("accepted input count", num_samples, in_count);
    if (out_count == in_count && exp_diff_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_failure("model queue did not drain, records missing at the output");
    end
  end

  // bound on the whole run
  always @(posedge s_axis_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Error at time %0d ns: run did not finish within %0d cycles",
               $time, timeout_cycles);
      fail_run();
    end
  end

endmodule
